/* include/fir_macros.svh */
`ifndef FIR_MACROS_SVH
`define FIR_MACROS_SVH

// Width of one input sample from the modulator
`define FIR_IN_WIDTH 1

// Input samples consumed per output word
`define FIR_DSR 4

// Taps in the newer and the older half of the history window
`define FIR_LOOKAHEAD 16
`define FIR_LOOKBACK 16

// Window bits that address one distributed-arithmetic table
`define FIR_LUT_SIZE 4

`define FIR_COEF_WIDTH 12
`define FIR_ACC_WIDTH 18
`define FIR_OUT_WIDTH 14

`endif

/* src/firPkg.sv */
`default_nettype none

`include "fir_macros.svh"

package firPkg;

    typedef logic signed [`FIR_COEF_WIDTH-1:0] coef_t;
    typedef coef_t coefSet_t [`FIR_LOOKAHEAD];
    typedef logic signed [`FIR_ACC_WIDTH-1:0] lutTable_t [2**`FIR_LUT_SIZE];

    // One history window, ahead half already in reversed order
    typedef struct packed {
        logic tick;
        logic [`FIR_LOOKAHEAD*`FIR_IN_WIDTH-1:0] ahead;
        logic [`FIR_LOOKBACK*`FIR_IN_WIDTH-1:0] back;
    } windowPkt_t;

    typedef struct packed {
        logic strobe;
        logic signed [`FIR_ACC_WIDTH-1:0] sum;
    } partialSum_t;

    // Index 0 is the tap next to the window centre for both halves
    localparam coefSet_t hAhead = '{
        12'sd1950, 12'sd1820, 12'sd1600, 12'sd1320,
        12'sd1010, 12'sd700,  12'sd420,  12'sd190,
        12'sd20,   -12'sd90,  -12'sd140, -12'sd150,
        -12'sd130, -12'sd100, -12'sd60,  -12'sd30
    };

    localparam coefSet_t hBack = '{
        12'sd1950, 12'sd1790, 12'sd1540, 12'sd1240,
        12'sd920,  12'sd610,  12'sd340,  12'sd130,
        -12'sd10,  -12'sd100, -12'sd145, -12'sd150,
        -12'sd125, -12'sd90,  -12'sd50,  -12'sd20
    };

    // Entry a holds the sum of the group coefficients whose address bit is set
    function automatic lutTable_t buildTable(input coefSet_t coefs, input int group);
        lutTable_t tbl;
        for (int a = 0; a < 2**`FIR_LUT_SIZE; a++) begin
            tbl[a] = '0;
            for (int b = 0; b < `FIR_LUT_SIZE; b++) begin
                if (a[b]) begin
                    tbl[a] = tbl[a] + `FIR_ACC_WIDTH'(coefs[group*`FIR_LUT_SIZE + b]);
                end
            end
        end
        return tbl;
    endfunction

endpackage

`default_nettype wire

/* src/decimTimer.sv */
`default_nettype none

`include "fir_macros.svh"

module decimTimer (
    input  wire  clk,
    input  wire  rst,
    output logic tick
);

    localparam int cntWidth = (`FIR_DSR > 1) ? $clog2(`FIR_DSR) : 1;
    localparam logic [cntWidth-1:0] lastCount = cntWidth'(`FIR_DSR - 1);

    logic [cntWidth-1:0] count;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (count == lastCount) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Tick marks the clock on which the last sample of a block is present
    assign tick = (count == lastCount);

endmodule

`default_nettype wire

/* src/sampleWindow.sv */
`default_nettype none

`include "fir_macros.svh"

module sampleWindow (
    input  wire                      clk,
    input  wire                      rst,
    input  wire [`FIR_IN_WIDTH-1:0]  in,
    input  wire                      tick,
    output firPkg::windowPkt_t       window
);

    localparam int sampleW = `FIR_IN_WIDTH;
    localparam int blockW = (`FIR_DSR - 1) * sampleW;
    localparam int winW = (`FIR_LOOKAHEAD + `FIR_LOOKBACK) * sampleW;
    localparam int aheadW = `FIR_LOOKAHEAD * sampleW;

    logic [blockW-1:0] block;
    logic [winW-1:0] history;
    logic tickReg;

    // Newest sample always sits at the low end
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            block <= '0;
        end else begin
            block <= {block[blockW-sampleW-1:0], in};
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            history <= '0;
            tickReg <= 1'b0;
        end else begin
            tickReg <= tick;
            if (tick) begin
                history <= {history[winW-`FIR_DSR*sampleW-1:0], block, in};
            end
        end
    end

    // The ahead half is handed on oldest first so that bit j pairs with hAhead[j]
    always_comb begin
        window.tick = tickReg;
        for (int j = 0; j < `FIR_LOOKAHEAD; j++) begin
            window.ahead[j*sampleW +: sampleW] =
                history[(`FIR_LOOKAHEAD-1-j)*sampleW +: sampleW];
        end
        window.back = history[winW-1:aheadW];
    end

endmodule

`default_nettype wire

/* src/daLutBank.sv */
`default_nettype none

`include "fir_macros.svh"

module daLutBank #(
    parameter firPkg::coefSet_t coefSet = firPkg::hAhead,
    parameter int numTaps = `FIR_LOOKAHEAD
) (
    input  wire                clk,
    input  wire                rst,
    input  wire [numTaps-1:0]  sel,
    input  wire                strobe,
    output firPkg::partialSum_t sum
);

    localparam int numGroups = numTaps / `FIR_LUT_SIZE;
    localparam int numPairs = numGroups / 2;

    logic signed [`FIR_ACC_WIDTH-1:0] lutOut [numGroups];
    logic signed [`FIR_ACC_WIDTH-1:0] pairSum [numPairs];
    logic signed [`FIR_ACC_WIDTH-1:0] treeSum;
    logic signed [`FIR_ACC_WIDTH-1:0] total;
    logic [2:0] strobeDly;

    // One constant table per group of four window bits
    genvar g;
    generate
        for (g = 0; g < numGroups; g++) begin : genLut
            localparam firPkg::lutTable_t lutTable = firPkg::buildTable(coefSet, g);

            always_ff @(posedge clk) begin
                lutOut[g] <= lutTable[sel[g*`FIR_LUT_SIZE +: `FIR_LUT_SIZE]];
            end
        end
    endgenerate

    // First tree level adds neighbouring tables
    always_ff @(posedge clk) begin
        for (int p = 0; p < numPairs; p++) begin
            pairSum[p] <= lutOut[2*p] + lutOut[2*p+1];
        end
    end

    always_comb begin
        treeSum = '0;
        for (int p = 0; p < numPairs; p++) begin
            treeSum = treeSum + pairSum[p];
        end
    end

    always_ff @(posedge clk) begin
        total <= treeSum;
    end

    // The strobe follows the data through lookup and both tree levels
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            strobeDly <= '0;
        end else begin
            strobeDly <= {strobeDly[1:0], strobe};
        end
    end

    assign sum.strobe = strobeDly[2];
    assign sum.sum = total;

endmodule

`default_nettype wire

/* src/outputStage.sv */
`default_nettype none

`include "fir_macros.svh"

module outputStage (
    input  wire                          clk,
    input  wire                          rst,
    input  wire firPkg::partialSum_t     ahead,
    input  wire firPkg::partialSum_t     back,
    output logic [`FIR_OUT_WIDTH-1:0]    out,
    output logic                         outStrobe,
    output logic                         valid
);

    localparam int shiftBits = `FIR_ACC_WIDTH - `FIR_OUT_WIDTH;
    // Number of blocks until the window holds only real samples
    localparam int fillCount = (`FIR_LOOKAHEAD + `FIR_LOOKBACK) / `FIR_DSR;
    localparam int cntWidth = $clog2(fillCount);

    logic signed [`FIR_ACC_WIDTH-1:0] fullSum;
    logic signed [`FIR_OUT_WIDTH-1:0] scaled;
    logic [cntWidth-1:0] strobeCount;

    assign fullSum = ahead.sum + back.sum;

    // Dropping the low bits is an arithmetic shift that rounds toward minus infinity
    assign scaled = fullSum[`FIR_ACC_WIDTH-1:shiftBits];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out <= '0;
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= ahead.strobe;
            if (ahead.strobe) begin
                out <= {~scaled[`FIR_OUT_WIDTH-1], scaled[`FIR_OUT_WIDTH-2:0]};
            end
        end
    end

    // Both banks run in lockstep, so the ahead strobe stands for the pair
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            strobeCount <= '0;
            valid <= 1'b0;
        end else if (ahead.strobe && !valid) begin
            if (strobeCount == cntWidth'(fillCount - 1)) begin
                valid <= 1'b1;
            end else begin
                strobeCount <= strobeCount + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/firDecimTop.sv */
`default_nettype none

`include "fir_macros.svh"

module firDecimTop (
    input  wire                         clk,
    input  wire                         rst,
    input  wire [`FIR_IN_WIDTH-1:0]     in,
    output logic [`FIR_OUT_WIDTH-1:0]   out,
    output logic                        outStrobe,
    output logic                        valid
);

    logic tick;
    firPkg::windowPkt_t window;
    firPkg::partialSum_t aheadSum;
    firPkg::partialSum_t backSum;

    decimTimer timer (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    sampleWindow sampler (
        .clk    (clk),
        .rst    (rst),
        .in     (in),
        .tick   (tick),
        .window (window)
    );

    // Newer half of the window, taps applied in reversed sample order
    daLutBank #(
        .coefSet (firPkg::hAhead),
        .numTaps (`FIR_LOOKAHEAD)
    ) aheadBank (
        .clk    (clk),
        .rst    (rst),
        .sel    (window.ahead),
        .strobe (window.tick),
        .sum    (aheadSum)
    );

    daLutBank #(
        .coefSet (firPkg::hBack),
        .numTaps (`FIR_LOOKBACK)
    ) backBank (
        .clk    (clk),
        .rst    (rst),
        .sel    (window.back),
        .strobe (window.tick),
        .sum    (backSum)
    );

    outputStage outStage (
        .clk       (clk),
        .rst       (rst),
        .ahead     (aheadSum),
        .back      (backSum),
        .out       (out),
        .outStrobe (outStrobe),
        .valid     (valid)
    );

endmodule

`default_nettype wire

/* tb/firChecker.sv */
`default_nettype none

`include "fir_macros.svh"

module firChecker (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       outStrobe,
    input  wire [`FIR_OUT_WIDTH-1:0]  out,
    input  wire                       valid,
    input  wire                       endCheck,
    output int                        valueErrors,
    output int                        otherErrors,
    output int                        compared,
    output int                        expectedCount
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int fillStrobes = (`FIR_LOOKAHEAD + `FIR_LOOKBACK) / `FIR_DSR;

    logic [`FIR_OUT_WIDTH-1:0] expected [$];
    int strobeCount;
    int gap;
    bit validSeen;
    bit countChecked;

    // Output words are the lines tagged o, in the order the DUT produces them
    task automatic loadExpected();
        int fd;
        int n;
        string line;
        string tag;
        logic [15:0] value;
        fd = $fopen("tb/fir_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/fir_golden.txt for the expected words");
            otherErrors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%s %h", tag, value) == 2 && tag == "o") begin
                expected.push_back(value[`FIR_OUT_WIDTH-1:0]);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        valueErrors = 0;
        otherErrors = 0;
        compared = 0;
        strobeCount = 0;
        gap = 0;
        loadExpected();
        expectedCount = expected.size();
    end

    always @(negedge clk) begin
        if (!rst || (strobeCount == 0 && !outStrobe)) begin
            if (outStrobe !== 1'b0) begin
                $display("[FAIL] outStrobe: expected 0x0, got 0x%h", outStrobe);
                valueErrors++;
            end
            if (valid !== 1'b0) begin
                $display("[FAIL] valid: expected 0x0, got 0x%h", valid);
                valueErrors++;
            end
            if (out !== '0) begin
                $display("[FAIL] out: expected 0x%04h, got 0x%04h", 14'h0, out);
                valueErrors++;
            end
        end
        if (rst) begin
            gap++;
            if (outStrobe) begin
                strobeCount++;
                if (strobeCount > 1 && gap != `FIR_DSR) begin
                    $display("outStrobe came %0d cycles after the previous one instead of %0d",
                        gap, `FIR_DSR);
                    otherErrors++;
                end
                gap = 0;
                if (valid && !validSeen && strobeCount != fillStrobes) begin
                    $display("valid rose with outStrobe number %0d instead of %0d",
                        strobeCount, fillStrobes);
                    otherErrors++;
                end
                if (!valid && strobeCount >= fillStrobes) begin
                    $display("valid is still low at outStrobe number %0d", strobeCount);
                    otherErrors++;
                end
                if (valid) begin
                    if (compared >= expected.size()) begin
                        $display("outStrobe number %0d has no expected word left", strobeCount);
                        otherErrors++;
                    end else begin
                        if (out !== expected[compared]) begin
                            $display("[FAIL] out: expected 0x%04h, got 0x%04h (word %0d)",
                                expected[compared], out, compared);
                            valueErrors++;
                        end
                        compared++;
                    end
                end
            end else if (valid && !validSeen) begin
                $display("valid rose on a cycle without outStrobe");
                otherErrors++;
            end
            if (validSeen && !valid) begin
                $display("valid dropped after it had gone high");
                otherErrors++;
            end
            if (valid) begin
                validSeen = 1'b1;
            end
        end
        if (endCheck && !countChecked) begin
            countChecked = 1'b1;
            if (compared != expected.size()) begin
                $display("Saw %0d checked outStrobe pulses but the golden file has %0d words",
                    compared, expected.size());
                otherErrors++;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/firDecimTb.sv */
`default_nettype none

`include "fir_macros.svh"

module firDecimTb;

    timeunit 1ns;
    timeprecision 1ps;

    // Cycles from the last tick until the word count is checked, one more than the output latency
    localparam int drainCycles = 5;

    bit clk;
    logic rst;
    logic [`FIR_IN_WIDTH-1:0] in;
    logic [`FIR_OUT_WIDTH-1:0] out;
    logic outStrobe;
    logic valid;
    logic endCheck;
    int valueErrors;
    int otherErrors;
    int compared;
    int expectedCount;

    bit stimBits [$];
    int loadErrors;

    always #50 clk = ~clk;

    firDecimTop firDecimTop_inst (
        .clk       (clk),
        .rst       (rst),
        .in        (in),
        .out       (out),
        .outStrobe (outStrobe),
        .valid     (valid)
    );

    firChecker outputCheck (
        .clk           (clk),
        .rst           (rst),
        .outStrobe     (outStrobe),
        .out           (out),
        .valid         (valid),
        .endCheck      (endCheck),
        .valueErrors   (valueErrors),
        .otherErrors   (otherErrors),
        .compared      (compared),
        .expectedCount (expectedCount)
    );

    // Each i line carries 16 input bits, driven most significant bit first
    task automatic loadStimulus();
        int fd;
        int n;
        string line;
        string tag;
        logic [15:0] value;
        fd = $fopen("tb/fir_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/fir_golden.txt for the input bits");
            loadErrors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%s %h", tag, value) == 2 && tag == "i") begin
                for (int b = 15; b >= 0; b--) begin
                    stimBits.push_back(value[b]);
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        rst = 1'b0;
        in = '0;
        endCheck = 1'b0;
        loadErrors = 0;
        loadStimulus();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        foreach (stimBits[k]) begin
            in = stimBits[k];
            @(posedge clk);
            #1;
        end
        in = '0;
        repeat (drainCycles) @(posedge clk);
        #1;
        endCheck = 1'b1;
        @(posedge clk);
        #1;
        $display("Compared %0d of %0d words: %0d value errors, %0d other errors",
            compared, expectedCount, valueErrors, otherErrors + loadErrors);
        if (valueErrors + otherErrors + loadErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Reset, every input bit and the pipeline latency fit well inside the limit
    initial begin
        longint limit;
        #1;
        limit = (longint'(stimBits.size()) + 40) * 100;
        #(limit);
        $display("Run timed out after %0d ns before all expected words arrived", limit);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/fir_golden.txt */
# i <16 input bits as hex, driven MSB first>
# o <expected 14-bit out word as hex, in order, once valid is high>
i 0000
i 0000
i 0000
o 2000
o 2000
o 2000
o 2000
o 2000
i FFFF
i FFFF
i FFFF
o 1FEC
o 1FD5
o 2066
o 2208
o 23A0
o 241D
o 2403
o 23F2
o 23F2
o 23F2
o 23F2
o 23F2
i 0000
i 0000
o 2406
o 241C
o 238B
o 21E9
o 2051
o 1FD4
o 1FEE
o 2000
i 4000
i 0000
o 1FF9
o 1FFA
o 202B
o 2071
o 2060
o 2015
o 1FF6
o 1FFC
i A5C3
i 96F0
o 1FF4
o 1FF0
o 203C
o 210B
o 21D0
o 2208
o 21CC
o 21F2

/* sim.f */
+incdir+include
src/firPkg.sv
src/decimTimer.sv
src/sampleWindow.sv
src/daLutBank.sv
src/outputStage.sv
src/firDecimTop.sv
tb/firChecker.sv
tb/firDecimTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= firDecimTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing
LINTFLAGS ?= --lint-only --timing
PASS_TEXT ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@result="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$result"; \
	echo "$$result" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
